//--- src.f
+incdir+common
+incdir+tests
common/mem_stage_pkg.sv
common/dmem_if.sv
src/store_unit.sv
src/load_unit.sv
dtim/dtim_bank.sv
memory_stage/memory_stage.sv
src/mem_subsystem_top.sv
tests/tb_mem_subsystem.sv

//--- tests/mem_ref_model.svh
`ifndef MEM_REF_MODEL_SVH
`define MEM_REF_MODEL_SVH

// shadow of the data memory, one entry per word.
logic [31:0] shadow [`DTIM_WORDS];

// expected writeback pairs, both lanes pushed together.
lane_t exp0_q[$];
lane_t exp1_q[$];

function automatic int unsigned word_of(input logic [31:0] addr);
  return (addr >> 2) % `DTIM_WORDS;
endfunction

function automatic logic model_loads(input lsu_op_t op);
  case (op)
    LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU: return 1'b1;
    default: return 1'b0;
  endcase
endfunction

task automatic model_store(input lane_t lane);
  int unsigned w;
  w = word_of(lane.addr);
  case (lane.op)
    LSU_SB: shadow[w][8*lane.addr[1:0] +: 8] = lane.sdata[7:0];
    LSU_SH: shadow[w][16*lane.addr[1] +: 16] = lane.sdata[15:0];
    LSU_SW: shadow[w] = lane.sdata;
    default: ;
  endcase
endtask

function automatic logic [31:0] model_load(input lane_t lane);
  logic [31:0] word;
  logic [7:0]  b;
  logic [15:0] h;
  word = shadow[word_of(lane.addr)];
  b    = word[8*lane.addr[1:0] +: 8];
  h    = word[16*lane.addr[1] +: 16];
  case (lane.op)
    LSU_LB:  return {{24{b[7]}}, b};
    LSU_LBU: return {24'd0, b};
    LSU_LH:  return {{16{h[15]}}, h};
    LSU_LHU: return {16'd0, h};
    default: return word;
  endcase
endfunction

// loads and alu results write the register file, never x0.
function automatic lane_t expect_lane(input lane_t lane);
  lane_t e;
  e      = lane;
  e.wren = lane.valid && (lane.waddr != 5'd0) &&
           (model_loads(lane.op) || (lane.op == LSU_NONE));
  if (model_loads(lane.op)) begin
    e.alu_data = model_load(lane);
  end
  return e;
endfunction

// both stores land before either load reads the word.
task automatic model_pair(input lane_t l0, input lane_t l1, input logic cleared);
  lane_t a;
  lane_t b;
  a = l0;
  b = l1;
  if (a.valid && (a.op == LSU_FENCE)) begin
    b.valid = 1'b0;
  end
  if (a.valid) begin
    model_store(a);
  end
  if (b.valid) begin
    model_store(b);
  end
  a = expect_lane(a);
  b = expect_lane(b);
  if (!cleared && (a.valid || b.valid)) begin
    exp0_q.push_back(a);
    exp1_q.push_back(b);
  end
endtask

`endif

//--- tests/tb_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_config.svh"

module tb_mem_subsystem
  import mem_stage_pkg::*;
();

  localparam int N_ALU = 40;
  localparam int N_FILL = 16;
  localparam int N_RAND = 200;
  localparam int N_OVERLAP = 8;
  localparam int N_FENCE = 8;
  localparam int N_CLEAR = 6;
  localparam int N_TESTS = 6;
  localparam int TOTAL_PAIRS = N_ALU + N_FILL + N_RAND + 2 * N_OVERLAP + 2 * N_FENCE +
                               3 * N_CLEAR + 4 * N_TESTS;
  localparam int CYCLE_LIMIT = 4 * TOTAL_PAIRS * (2 + `DTIM_WAIT) + 100;

  logic        clock;
  logic        reset;
  logic        clear;
  lane_t       in0;
  lane_t       in1;
  logic        stall;
  logic        wb0_valid, wb0_wren, wb1_valid, wb1_wren;
  logic [4:0]  wb0_waddr, wb1_waddr, fwd0_waddr, fwd1_waddr;
  logic [31:0] wb0_wdata, wb1_wdata, fwd0_wdata, fwd1_wdata;
  logic        fwd0_wren, fwd1_wren;
  logic        alu_phase = 1'b0;
  int          err_count = 0;
  int          check_count = 0;
  int          test_count = 0;
  int          cycles = 0;

  // fwd outputs seen one falling edge before the writeback.
  logic        last_fwd0_wren;
  logic        last_fwd1_wren;
  logic [4:0]  last_fwd0_waddr;
  logic [4:0]  last_fwd1_waddr;
  logic [31:0] last_fwd0_wdata;
  logic [31:0] last_fwd1_wdata;

  `include "mem_ref_model.svh"

  mem_subsystem_top uut (
    .clock (clock), .reset (reset), .clear (clear),
    .lane0_valid (in0.valid), .lane0_op (in0.op), .lane0_addr (in0.addr),
    .lane0_sdata (in0.sdata), .lane0_waddr (in0.waddr), .lane0_alu_data (in0.alu_data),
    .lane1_valid (in1.valid), .lane1_op (in1.op), .lane1_addr (in1.addr),
    .lane1_sdata (in1.sdata), .lane1_waddr (in1.waddr), .lane1_alu_data (in1.alu_data),
    .stall (stall),
    .wb0_valid (wb0_valid), .wb0_wren (wb0_wren), .wb0_waddr (wb0_waddr),
    .wb0_wdata (wb0_wdata),
    .wb1_valid (wb1_valid), .wb1_wren (wb1_wren), .wb1_waddr (wb1_waddr),
    .wb1_wdata (wb1_wdata),
    .fwd0_wren (fwd0_wren), .fwd0_waddr (fwd0_waddr), .fwd0_wdata (fwd0_wdata),
    .fwd1_wren (fwd1_wren), .fwd1_waddr (fwd1_waddr), .fwd1_wdata (fwd1_wdata)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_lane(input int n, input lane_t e, input logic valid, input logic wren,
                            input logic [4:0] waddr, input logic [31:0] wdata);
    check_val($sformatf("wb%0d_valid", n), valid, e.valid);
    if (e.valid) begin
      check_val($sformatf("wb%0d_wren", n), wren, e.wren);
      check_val($sformatf("wb%0d_waddr", n), waddr, e.waddr);
      check_val($sformatf("wb%0d_wdata", n), wdata, e.alu_data);
    end
  endtask

  // finished lane as forwarded in the cycle before writeback.
  task automatic check_forward(input int n, input lane_t e, input logic wren,
                               input logic [4:0] waddr, input logic [31:0] wdata);
    check_val($sformatf("fwd%0d_wren", n), wren, e.wren);
    if (e.valid) begin
      check_val($sformatf("fwd%0d_waddr", n), waddr, e.waddr);
      check_val($sformatf("fwd%0d_wdata", n), wdata, e.alu_data);
    end
  endtask

  always @(negedge clock) begin : wb_monitor
    lane_t e0;
    lane_t e1;
    if (reset && alu_phase) begin
      check_val("stall", stall, 32'd0);
    end
    if (reset && (wb0_valid || wb1_valid)) begin
      if (exp0_q.size() == 0) begin
        err_count++;
        $display("a writeback pair arrived when none was expected");
      end else begin
        e0 = exp0_q.pop_front();
        e1 = exp1_q.pop_front();
        check_lane(0, e0, wb0_valid, wb0_wren, wb0_waddr, wb0_wdata);
        check_lane(1, e1, wb1_valid, wb1_wren, wb1_waddr, wb1_wdata);
        check_forward(0, e0, last_fwd0_wren, last_fwd0_waddr, last_fwd0_wdata);
        check_forward(1, e1, last_fwd1_wren, last_fwd1_waddr, last_fwd1_wdata);
      end
    end
    last_fwd0_wren  = fwd0_wren;
    last_fwd0_waddr = fwd0_waddr;
    last_fwd0_wdata = fwd0_wdata;
    last_fwd1_wren  = fwd1_wren;
    last_fwd1_waddr = fwd1_waddr;
    last_fwd1_wdata = fwd1_wdata;
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
               err_count);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]};
  endfunction

  // window of 32 words, upper address bits alias onto it.
  function automatic logic [31:0] rand_addr(input lsu_op_t op);
    logic [31:0] a;
    a = ($urandom & 32'hffff_fc00) | (($urandom % 32) << 2) | ($urandom & 3);
    case (op)
      LSU_SB, LSU_LB, LSU_LBU: ;
      LSU_SH, LSU_LH, LSU_LHU: a[0] = 1'b0;
      default: a[1:0] = 2'b00;
    endcase
    return a;
  endfunction

  function automatic lane_t make_lane(input lsu_op_t op, input logic [31:0] addr,
                                      input logic [31:0] sdata);
    lane_t l;
    l          = '0;
    l.valid    = 1'b1;
    l.op       = op;
    l.addr     = addr;
    l.sdata    = sdata;
    l.waddr    = 5'(1 + $urandom % 31);
    l.alu_data = $urandom;
    return l;
  endfunction

  function automatic lane_t rand_lane(input logic with_mem);
    lane_t l;
    l          = '0;
    l.valid    = ($urandom % 8) != 0;
    l.op       = with_mem ? lsu_op_t'(4'($urandom % 10)) : LSU_NONE;
    l.addr     = rand_addr(l.op);
    l.sdata    = $urandom;
    l.waddr    = (($urandom % 4) == 0) ? 5'd0 : 5'($urandom);
    l.alu_data = $urandom;
    return l;
  endfunction

  function automatic lsu_op_t pick_store();
    case ($urandom % 3)
      0: return LSU_SB;
      1: return LSU_SH;
      default: return LSU_SW;
    endcase
  endfunction

  // hold the pair until a falling edge sees stall low.
  task automatic send_pair(input lane_t l0, input lane_t l1, input logic cleared = 1'b0);
    @(negedge clock);
    in0 = l0;
    in1 = l1;
    while (stall) begin
      @(negedge clock);
    end
    model_pair(l0, l1, cleared);
  endtask

  task automatic send_cleared(input lane_t l0, input lane_t l1);
    send_pair(l0, l1, 1'b1);
    @(negedge clock);
    clear = 1'b1;
    @(negedge clock);
    clear = 1'b0;
    in0 = '0;
    in1 = '0;
    check_val("stall", stall, 32'd0);
  endtask

  task automatic finish_test(input string name, input int start_err);
    @(negedge clock);
    in0 = '0;
    in1 = '0;
    #2;
    while (stall || (exp0_q.size() != 0)) begin
      @(negedge clock);
      #2;
    end
    test_count++;
    $display("test %s done, %0d errors", name, err_count - start_err);
  endtask

  initial begin
    int    start_err;
    lane_t a;
    lane_t b;
    void'($urandom(32'hc906));
    reset = 1'b0;
    clear = 1'b0;
    in0 = '0;
    in1 = '0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;

    start_err = err_count;
    check_val("stall", stall, 32'd0);
    check_val("wb0_valid", wb0_valid, 32'd0);
    check_val("wb1_valid", wb1_valid, 32'd0);
    check_val("fwd0_wren", fwd0_wren, 32'd0);
    check_val("fwd1_wren", fwd1_wren, 32'd0);
    finish_test("reset", start_err);

    start_err = err_count;
    alu_phase = 1'b1;
    for (int i = 0; i < N_ALU; i++) begin
      send_pair(rand_lane(1'b0), rand_lane(1'b0));
    end
    finish_test("alu_only", start_err);
    alu_phase = 1'b0;

    start_err = err_count;
    for (int k = 0; k < N_FILL; k++) begin
      send_pair(make_lane(LSU_SW, 8 * k, fill_word(8 * k)),
                make_lane(LSU_SW, 8 * k + 4, fill_word(8 * k + 4)));
    end
    for (int i = 0; i < N_RAND; i++) begin
      send_pair(rand_lane(1'b1), rand_lane(1'b1));
    end
    finish_test("random_load_store", start_err);

    start_err = err_count;
    for (int i = 0; i < N_OVERLAP; i++) begin
      a = make_lane(pick_store(), 0, $urandom);
      a.addr = rand_addr(a.op);
      b = make_lane(pick_store(), 0, $urandom);
      b.addr = rand_addr(b.op);
      b.addr[31:2] = a.addr[31:2];
      send_pair(a, b);
      send_pair(make_lane(LSU_LW, {a.addr[31:2], 2'b00}, 0),
                make_lane(LSU_LBU, a.addr, 0));
    end
    finish_test("same_word_stores", start_err);

    start_err = err_count;
    for (int i = 0; i < N_FENCE; i++) begin
      a = make_lane(LSU_FENCE, 0, 0);
      b = make_lane(LSU_SW, rand_addr(LSU_SW), $urandom);
      send_pair(a, b);
      send_pair(make_lane(LSU_LW, b.addr, 0), make_lane(LSU_LHU, b.addr, 0));
    end
    finish_test("fence_squash", start_err);

    start_err = err_count;
    for (int i = 0; i < N_CLEAR; i++) begin
      a = make_lane(LSU_SW, rand_addr(LSU_SW), $urandom);
      b = make_lane(LSU_SB, rand_addr(LSU_SB), $urandom);
      send_cleared(a, b);
      send_pair(make_lane(LSU_LW, a.addr, 0), make_lane(LSU_LB, b.addr, 0));
    end
    finish_test("clear_in_flight", start_err);

    $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src/mem_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_config.svh"

module mem_subsystem_top
  import mem_stage_pkg::*;
(
  input  logic             clock,
  input  logic             reset,
  input  logic             clear,
  input  logic             lane0_valid,
  input  lsu_op_t          lane0_op,
  input  logic [`XLEN-1:0] lane0_addr,
  input  logic [`XLEN-1:0] lane0_sdata,
  input  logic [4:0]       lane0_waddr,
  input  logic [`XLEN-1:0] lane0_alu_data,
  input  logic             lane1_valid,
  input  lsu_op_t          lane1_op,
  input  logic [`XLEN-1:0] lane1_addr,
  input  logic [`XLEN-1:0] lane1_sdata,
  input  logic [4:0]       lane1_waddr,
  input  logic [`XLEN-1:0] lane1_alu_data,
  output logic             stall,
  output logic             wb0_valid,
  output logic             wb0_wren,
  output logic [4:0]       wb0_waddr,
  output logic [`XLEN-1:0] wb0_wdata,
  output logic             wb1_valid,
  output logic             wb1_wren,
  output logic [4:0]       wb1_waddr,
  output logic [`XLEN-1:0] wb1_wdata,
  output logic             fwd0_wren,
  output logic [4:0]       fwd0_waddr,
  output logic [`XLEN-1:0] fwd0_wdata,
  output logic             fwd1_wren,
  output logic [4:0]       fwd1_waddr,
  output logic [`XLEN-1:0] fwd1_wdata
);

  lane_t            lane0_in;
  lane_t            lane1_in;
  lane_t            wb0;
  lane_t            wb1;
  lane_t            fwd0;
  lane_t            fwd1;
  logic [`XLEN-1:0] store0_wdata;
  logic [3:0]       store0_wstrb;
  logic [`XLEN-1:0] store1_wdata;
  logic [3:0]       store1_wstrb;
  logic [`XLEN-1:0] load0_data;
  logic [`XLEN-1:0] load1_data;

  dmem_if dmem0 ();
  dmem_if dmem1 ();

  // wren is filled in by the stage.
  assign lane0_in = '{valid: lane0_valid, op: lane0_op, addr: lane0_addr, sdata: lane0_sdata,
                      waddr: lane0_waddr, alu_data: lane0_alu_data, wren: 1'b0};
  assign lane1_in = '{valid: lane1_valid, op: lane1_op, addr: lane1_addr, sdata: lane1_sdata,
                      waddr: lane1_waddr, alu_data: lane1_alu_data, wren: 1'b0};

  store_unit u_store0 (
    .op    (lane0_op),
    .addr  (lane0_addr),
    .sdata (lane0_sdata),
    .wdata (store0_wdata),
    .wstrb (store0_wstrb)
  );

  store_unit u_store1 (
    .op    (lane1_op),
    .addr  (lane1_addr),
    .sdata (lane1_sdata),
    .wdata (store1_wdata),
    .wstrb (store1_wstrb)
  );

  // registered lane picks the bytes out of the returned word.
  load_unit u_load0 (
    .op     (fwd0.op),
    .addr   (fwd0.addr[1:0]),
    .rdata  (dmem0.rdata),
    .result (load0_data)
  );

  load_unit u_load1 (
    .op     (fwd1.op),
    .addr   (fwd1.addr[1:0]),
    .rdata  (dmem1.rdata),
    .result (load1_data)
  );

  memory_stage u_stage (
    .clock        (clock),
    .reset        (reset),
    .clear        (clear),
    .lane0_in     (lane0_in),
    .lane1_in     (lane1_in),
    .dmem0        (dmem0.requester),
    .dmem1        (dmem1.requester),
    .store0_wdata (store0_wdata),
    .store0_wstrb (store0_wstrb),
    .store1_wdata (store1_wdata),
    .store1_wstrb (store1_wstrb),
    .load0_data   (load0_data),
    .load1_data   (load1_data),
    .stall        (stall),
    .wb0          (wb0),
    .wb1          (wb1),
    .fwd0         (fwd0),
    .fwd1         (fwd1)
  );

  dtim_bank u_dtim (
    .clock (clock),
    .reset (reset),
    .port0 (dmem0.memory),
    .port1 (dmem1.memory)
  );

  assign wb0_valid  = wb0.valid;
  assign wb0_wren   = wb0.wren;
  assign wb0_waddr  = wb0.waddr;
  assign wb0_wdata  = wb0.alu_data;
  assign wb1_valid  = wb1.valid;
  assign wb1_wren   = wb1.wren;
  assign wb1_waddr  = wb1.waddr;
  assign wb1_wdata  = wb1.alu_data;

  assign fwd0_wren  = fwd0.wren;
  assign fwd0_waddr = fwd0.waddr;
  assign fwd0_wdata = fwd0.alu_data;
  assign fwd1_wren  = fwd1.wren;
  assign fwd1_waddr = fwd1.waddr;
  assign fwd1_wdata = fwd1.alu_data;

endmodule

`default_nettype wire

//--- memory_stage/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_config.svh"

module memory_stage
  import mem_stage_pkg::*;
(
  input  logic             clock,
  input  logic             reset,
  input  logic             clear,
  input  lane_t            lane0_in,
  input  lane_t            lane1_in,
  dmem_if.requester        dmem0,
  dmem_if.requester        dmem1,
  input  logic [`XLEN-1:0] store0_wdata,
  input  logic [3:0]       store0_wstrb,
  input  logic [`XLEN-1:0] store1_wdata,
  input  logic [3:0]       store1_wstrb,
  input  logic [`XLEN-1:0] load0_data,
  input  logic [`XLEN-1:0] load1_data,
  output logic             stall,
  output lane_t            wb0,
  output lane_t            wb1,
  output lane_t            fwd0,
  output lane_t            fwd1
);

  mem_reg_t   r;
  mem_reg_t   r_next;
  logic [1:0] pend;
  logic [1:0] pend_next;
  logic       accept;
  logic       squash;
  logic       issue0;
  logic       issue1;

  // loads and alu results write the register file, x0 never.
  function automatic lane_t prepare(input lane_t lane);
    lane_t res;
    res = lane;
    res.wren = lane.valid && (lane.waddr != 5'd0) &&
               (is_load(lane.op) || (lane.op == LSU_NONE));
    return res;
  endfunction

  function automatic lane_t finish(input lane_t lane, input logic pending,
                                   input logic ready, input logic [`XLEN-1:0] fresh,
                                   input logic [`XLEN-1:0] held);
    lane_t res;
    res = lane;
    if (is_load(lane.op)) begin
      res.alu_data = pending ? fresh : held;
      res.wren     = lane.wren && (!pending || ready);
    end
    return res;
  endfunction

  assign accept = !r.stall && !clear;
  assign squash = lane0_in.valid && (lane0_in.op == LSU_FENCE);
  assign issue0 = accept && lane0_in.valid && is_mem(lane0_in.op);
  assign issue1 = accept && lane1_in.valid && is_mem(lane1_in.op) && !squash;

  assign dmem0.valid = issue0;
  assign dmem0.fence = (lane0_in.op == LSU_FENCE);
  assign dmem0.addr  = lane0_in.addr;
  assign dmem0.wdata = store0_wdata;
  assign dmem0.wstrb = store0_wstrb;

  assign dmem1.valid = issue1;
  assign dmem1.fence = (lane1_in.op == LSU_FENCE);
  assign dmem1.addr  = lane1_in.addr;
  assign dmem1.wdata = store1_wdata;
  assign dmem1.wstrb = store1_wstrb;

  always_comb begin
    r_next    = r;
    pend_next = pend;
    if (r.stall) begin
      if (pend[0] && dmem0.ready) begin
        pend_next[0]  = 1'b0;
        r_next.rdata0 = load0_data;
      end
      if (pend[1] && dmem1.ready) begin
        pend_next[1]  = 1'b0;
        r_next.rdata1 = load1_data;
      end
      r_next.stall = |pend_next;
    end else begin
      r_next.lane0 = prepare(lane0_in);
      r_next.lane1 = prepare(lane1_in);
      // fence in lane 0 kills its partner.
      if (squash) begin
        r_next.lane1.valid = 1'b0;
        r_next.lane1.wren  = 1'b0;
      end
      pend_next    = {issue1, issue0};
      r_next.stall = issue0 || issue1;
    end
    if (clear) begin
      r_next.lane0.valid = 1'b0;
      r_next.lane0.wren  = 1'b0;
      r_next.lane1.valid = 1'b0;
      r_next.lane1.wren  = 1'b0;
      r_next.stall       = 1'b0;
      pend_next          = 2'b00;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      r.lane0.valid <= 1'b0;
      r.lane0.wren  <= 1'b0;
      r.lane1.valid <= 1'b0;
      r.lane1.wren  <= 1'b0;
      r.stall       <= 1'b0;
      pend          <= 2'b00;
    end else begin
      r    <= r_next;
      pend <= pend_next;
    end
  end

  assign fwd0  = finish(r.lane0, pend[0], dmem0.ready, load0_data, r.rdata0);
  assign fwd1  = finish(r.lane1, pend[1], dmem1.ready, load1_data, r.rdata1);
  assign stall = r.stall;

  // once stall is low the forwarded lanes are the finished pair.
  always_ff @(posedge clock) begin
    if (!reset) begin
      wb0.valid <= 1'b0;
      wb0.wren  <= 1'b0;
      wb1.valid <= 1'b0;
      wb1.wren  <= 1'b0;
    end else if (!r.stall && !clear) begin
      wb0 <= fwd0;
      wb1 <= fwd1;
    end else begin
      wb0.valid <= 1'b0;
      wb0.wren  <= 1'b0;
      wb1.valid <= 1'b0;
      wb1.wren  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- dtim/dtim_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_config.svh"

module dtim_bank (
  input logic    clock,
  input logic    reset,
  dmem_if.memory port0,
  dmem_if.memory port1
);

  localparam int unsigned IW = $clog2(`DTIM_WORDS);
  localparam int unsigned CW = $clog2(`DTIM_WAIT + 2);

  logic [`XLEN-1:0] mem [`DTIM_WORDS];

  logic [1:0]       req_valid;
  logic [1:0]       req_fence;
  logic [`XLEN-1:0] req_addr [2];
  logic [`XLEN-1:0] req_wdata [2];
  logic [3:0]       req_wstrb [2];

  logic [1:0]    pend;
  logic [CW-1:0] cnt [2];
  logic [IW-1:0] idx [2];
  logic [1:0]    ready;

  function automatic logic [IW-1:0] word_index(input logic [`XLEN-1:0] addr);
    return IW'((addr >> 2) % `DTIM_WORDS);
  endfunction

  assign req_valid    = {port1.valid, port0.valid};
  assign req_fence    = {port1.fence, port0.fence};
  assign req_addr[0]  = port0.addr;
  assign req_addr[1]  = port1.addr;
  assign req_wdata[0] = port0.wdata;
  assign req_wdata[1] = port1.wdata;
  assign req_wstrb[0] = port0.wstrb;
  assign req_wstrb[1] = port1.wstrb;

  // port 1 comes later in the loop, so it wins on overlapping bytes.
  always_ff @(posedge clock) begin
    for (int p = 0; p < 2; p++) begin
      if (req_valid[p]) begin
        idx[p] <= word_index(req_addr[p]);
      end
      for (int b = 0; b < 4; b++) begin
        if (req_valid[p] && !req_fence[p] && req_wstrb[p][b]) begin
          mem[word_index(req_addr[p])][8*b +: 8] <= req_wdata[p][8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      pend   <= 2'b00;
      cnt[0] <= '0;
      cnt[1] <= '0;
    end else begin
      for (int p = 0; p < 2; p++) begin
        if (req_valid[p]) begin
          pend[p] <= 1'b1;
          cnt[p]  <= CW'(`DTIM_WAIT);
        end else if (ready[p]) begin
          pend[p] <= 1'b0;
        end else if (pend[p] && (cnt[p] != '0)) begin
          cnt[p] <= cnt[p] - 1'b1;
        end
      end
    end
  end

  assign ready[0] = pend[0] && (cnt[0] == '0);
  assign ready[1] = pend[1] && (cnt[1] == '0);

  // read sees both writes of the sampling edge.
  assign port0.ready = ready[0];
  assign port0.rdata = mem[idx[0]];
  assign port1.ready = ready[1];
  assign port1.rdata = mem[idx[1]];

endmodule

`default_nettype wire

//--- src/load_unit.sv
`timescale 1ns/1ps
`default_nettype none

module load_unit
  import mem_stage_pkg::*;
(
  input  lsu_op_t     op,
  input  logic [1:0]  addr,
  input  logic [31:0] rdata,
  output logic [31:0] result
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  assign byte_sel = rdata[8*addr +: 8];
  assign half_sel = addr[1] ? rdata[31:16] : rdata[15:0];

  always_comb begin
    case (op)
      LSU_LB: begin
        result = {{24{byte_sel[7]}}, byte_sel};
      end
      LSU_LBU: begin
        result = {24'd0, byte_sel};
      end
      LSU_LH: begin
        result = {{16{half_sel[15]}}, half_sel};
      end
      LSU_LHU: begin
        result = {16'd0, half_sel};
      end
      default: begin
        // full word.
        result = rdata;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- src/store_unit.sv
`timescale 1ns/1ps
`default_nettype none

module store_unit
  import mem_stage_pkg::*;
(
  input  lsu_op_t     op,
  input  logic [31:0] addr,
  input  logic [31:0] sdata,
  output logic [31:0] wdata,
  output logic [3:0]  wstrb
);

  always_comb begin
    wdata = sdata;
    wstrb = 4'b0000;
    case (op)
      LSU_SB: begin
        wdata = {4{sdata[7:0]}};
        wstrb = 4'b0001 << addr[1:0];
      end
      LSU_SH: begin
        wdata = {2{sdata[15:0]}};
        // only the upper or lower half, bit 0 is ignored.
        wstrb = addr[1] ? 4'b1100 : 4'b0011;
      end
      LSU_SW: begin
        wstrb = 4'b1111;
      end
      default: begin
        wstrb = 4'b0000;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- common/dmem_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_config.svh"

interface dmem_if;

  logic             valid;
  logic             fence;
  logic [`XLEN-1:0] addr;
  logic [`XLEN-1:0] wdata;
  logic [3:0]       wstrb;
  logic [`XLEN-1:0] rdata;
  logic             ready;

  modport requester (
    output valid, fence, addr, wdata, wstrb,
    input  rdata, ready
  );

  modport memory (
    input  valid, fence, addr, wdata, wstrb,
    output rdata, ready
  );

endinterface

`default_nettype wire

//--- common/mem_stage_pkg.sv
`default_nettype none

`include "mem_stage_config.svh"

package mem_stage_pkg;

  typedef enum logic [3:0] {
    LSU_NONE  = 4'd0,
    LSU_LB    = 4'd1,
    LSU_LH    = 4'd2,
    LSU_LW    = 4'd3,
    LSU_LBU   = 4'd4,
    LSU_LHU   = 4'd5,
    LSU_SB    = 4'd6,
    LSU_SH    = 4'd7,
    LSU_SW    = 4'd8,
    LSU_FENCE = 4'd9
  } lsu_op_t;

  // one instruction slot of the pair.
  typedef struct packed {
    logic             valid;
    lsu_op_t          op;
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] sdata;
    logic [4:0]       waddr;
    logic [`XLEN-1:0] alu_data;
    logic             wren;
  } lane_t;

  typedef struct packed {
    lane_t            lane0;
    lane_t            lane1;
    logic             stall;
    logic [`XLEN-1:0] rdata0;
    logic [`XLEN-1:0] rdata1;
  } mem_reg_t;

  function automatic logic is_load(input lsu_op_t op);
    return (op == LSU_LB) || (op == LSU_LH) || (op == LSU_LW) ||
           (op == LSU_LBU) || (op == LSU_LHU);
  endfunction

  function automatic logic is_store(input lsu_op_t op);
    return (op == LSU_SB) || (op == LSU_SH) || (op == LSU_SW);
  endfunction

  // anything that needs a data memory port.
  function automatic logic is_mem(input lsu_op_t op);
    return is_load(op) || is_store(op) || (op == LSU_FENCE);
  endfunction

endpackage

`default_nettype wire

//--- common/mem_stage_config.svh
`ifndef MEM_STAGE_CONFIG_SVH
`define MEM_STAGE_CONFIG_SVH

// data and address width.
`define XLEN 32

// data memory depth in 32-bit words.
`define DTIM_WORDS 256

// extra cycles a port waits before ready.
`define DTIM_WAIT 1

`endif
